// File: logic/decode_pkg.sv
`default_nettype none

package decode_pkg;

    localparam int ISA_WIDTH           = 32;    // machine word
    localparam int ADDRESS_WIDTH       = 26;    // j and jal target field
    localparam int REG_FILE_ADDR_WIDTH = 5;     // 32 general registers
    localparam int SHIFT_AMOUNT_WIDTH  = 5;     // shamt field
    localparam int IMMEDIATE_WIDTH     = 16;    // i type immediate field
    localparam int OPCODE_WIDTH        = 6;
    localparam int FUNCT_WIDTH         = 6;
    localparam int ALU_OP_WIDTH        = 4;

    typedef logic [ISA_WIDTH-1:0]           isa_word_t;     // instruction, pc or operand
    typedef logic [REG_FILE_ADDR_WIDTH-1:0] reg_idx_t;
    typedef logic [SHIFT_AMOUNT_WIDTH-1:0]  shift_amt_t;
    typedef logic [OPCODE_WIDTH-1:0]        opcode_t;
    typedef logic [FUNCT_WIDTH-1:0]         funct_t;
    typedef logic [ALU_OP_WIDTH-1:0]        alu_op_t;

    // alu operation codes seen by execute
    localparam alu_op_t ALU_ADD = 4'd0;
    localparam alu_op_t ALU_SUB = 4'd1;     // also used for branch compare
    localparam alu_op_t ALU_AND = 4'd2;
    localparam alu_op_t ALU_OR  = 4'd3;
    localparam alu_op_t ALU_SLT = 4'd4;
    localparam alu_op_t ALU_SLL = 4'd5;
    localparam alu_op_t ALU_SRL = 4'd6;
    localparam alu_op_t ALU_NOP = 4'd15;    // bubble and unknown encodings

    localparam opcode_t OP_RTYPE = 6'h00;   // funct selects the operation
    localparam opcode_t OP_J     = 6'h02;
    localparam opcode_t OP_JAL   = 6'h03;
    localparam opcode_t OP_BEQ   = 6'h04;   // bit 0 clear, taken on equal
    localparam opcode_t OP_BNE   = 6'h05;   // bit 0 set, taken on not equal
    localparam opcode_t OP_ADDI  = 6'h08;
    localparam opcode_t OP_SLTI  = 6'h0a;
    localparam opcode_t OP_ANDI  = 6'h0c;   // 0011xx marks logical immediates
    localparam opcode_t OP_ORI   = 6'h0d;

    localparam funct_t FN_SLL = 6'h00;
    localparam funct_t FN_SRL = 6'h02;
    localparam funct_t FN_JR  = 6'h08;
    localparam funct_t FN_ADD = 6'h20;
    localparam funct_t FN_SUB = 6'h22;
    localparam funct_t FN_AND = 6'h24;
    localparam funct_t FN_OR  = 6'h25;
    localparam funct_t FN_SLT = 6'h2a;

    localparam reg_idx_t JAL_REG_IDX = 5'd31;   // link register written by jal

endpackage

`default_nettype wire

// File: logic/control_unit.sv
`timescale 1ns/100ps
`default_nettype none

module control_unit import decode_pkg::*; (
    input  isa_word_t id_instruction,       // current instruction from fetch
    output logic      i_type_instruction,   // addi, slti, andi, ori
    output logic      r_type_instruction,   // alu r type including shifts
    output logic      j_instruction,
    output logic      jr_instruction,
    output logic      jal_instruction,
    output logic      branch_instruction,   // beq or bne
    output logic      shift_instruction,    // sll or srl, rides with r type
    output alu_op_t   alu_op,
    output logic      reg_write_intent      // destination write wanted
);

    opcode_t opcode;
    funct_t  funct;

    assign opcode = id_instruction[ISA_WIDTH-1 -: OPCODE_WIDTH];
    assign funct  = id_instruction[FUNCT_WIDTH-1:0];

    always_comb begin
        i_type_instruction = 1'b0;     // unknown encodings leave all strobes low
        r_type_instruction = 1'b0;
        j_instruction      = 1'b0;
        jr_instruction     = 1'b0;
        jal_instruction    = 1'b0;
        branch_instruction = 1'b0;
        shift_instruction  = 1'b0;
        alu_op             = ALU_NOP;
        reg_write_intent   = 1'b0;
        case (opcode)
            OP_RTYPE: begin
                case (funct)
                    FN_ADD:  alu_op = ALU_ADD;
                    FN_SUB:  alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_SLT:  alu_op = ALU_SLT;
                    FN_SLL:  alu_op = ALU_SLL;
                    FN_SRL:  alu_op = ALU_SRL;
                    default: alu_op = ALU_NOP;     // jr and undefined functs
                endcase
                jr_instruction     = (funct == FN_JR);     // jr is its own class
                r_type_instruction = (alu_op != ALU_NOP);
                shift_instruction  = (funct == FN_SLL) || (funct == FN_SRL);
                reg_write_intent   = r_type_instruction;
            end
            OP_ADDI, OP_SLTI, OP_ANDI, OP_ORI: begin
                i_type_instruction = 1'b1;
                reg_write_intent   = 1'b1;     // result lands in rt
                case (opcode)
                    OP_SLTI: alu_op = ALU_SLT;
                    OP_ANDI: alu_op = ALU_AND;
                    OP_ORI:  alu_op = ALU_OR;
                    default: alu_op = ALU_ADD;
                endcase
            end
            OP_BEQ, OP_BNE: begin
                branch_instruction = 1'b1;
                alu_op             = ALU_SUB;  // compare only, no write
            end
            OP_J: begin
                j_instruction = 1'b1;
            end
            OP_JAL: begin
                jal_instruction  = 1'b1;
                alu_op           = ALU_ADD;    // pc + 4 into the link register
                reg_write_intent = 1'b1;
            end
            default: ;
        endcase
    end

    // downstream muxes rely on the classes never overlapping
    always_comb begin
        assert ($onehot0({i_type_instruction, r_type_instruction, branch_instruction,
                          j_instruction, jal_instruction, jr_instruction}))
            else $error("control_unit: more than one instruction class active");
    end

endmodule

`default_nettype wire

// File: logic/branch_resolver.sv
`timescale 1ns/100ps
`default_nettype none

module branch_resolver import decode_pkg::*; (
    input  isa_word_t id_instruction,          // current instruction
    input  isa_word_t id_reg_1,                // rs value from the register file
    input  isa_word_t id_reg_2,                // rt value from the register file
    output isa_word_t id_sign_extend_result,   // extended 16 bit immediate
    output logic      condition_satisfied      // branch condition holds
);

    opcode_t                    opcode;
    logic [IMMEDIATE_WIDTH-1:0] immediate;
    logic                       logical_imm;
    logic                       regs_equal;

    assign opcode    = id_instruction[ISA_WIDTH-1 -: OPCODE_WIDTH];
    assign immediate = id_instruction[IMMEDIATE_WIDTH-1:0];

    // andi and ori both start with 0011, everything else is signed
    assign logical_imm = (opcode[OPCODE_WIDTH-1 -: 4] == 4'b0011);

    always_comb begin
        if (logical_imm) begin
            id_sign_extend_result = {{(ISA_WIDTH-IMMEDIATE_WIDTH){1'b0}}, immediate};
        end else begin
            id_sign_extend_result = {{(ISA_WIDTH-IMMEDIATE_WIDTH){immediate[IMMEDIATE_WIDTH-1]}},
                                     immediate};
        end
    end

    assign regs_equal = (id_reg_1 == id_reg_2);   // full word compare

    // opcode bit 0 flips the sense, beq on equal and bne on not equal
    assign condition_satisfied = regs_equal ^ opcode[0];

endmodule

`default_nettype wire

// File: logic/signal_mux.sv
`timescale 1ns/100ps
`default_nettype none

module signal_mux import decode_pkg::*; (
    input  logic       clk,                      // only for the redirect check
    input  logic       rst_n,
    input  logic       i_type_instruction,       // class strobes from control_unit
    input  logic       r_type_instruction,
    input  logic       j_instruction,
    input  logic       jr_instruction,
    input  logic       jal_instruction,
    input  logic       branch_instruction,
    input  logic       shift_instruction,
    input  logic       condition_satisfied,      // from branch_resolver
    input  logic       id_no_op,                 // gap in the instruction stream
    output logic       pc_offset,                // taken branch, fetch adds offset
    output logic       pc_overload,              // jump, fetch loads a new pc
    input  isa_word_t  id_reg_1,                 // rs value
    input  isa_word_t  id_pc,
    input  shift_amt_t shift_amount,             // shamt field
    output isa_word_t  mux_operand_1,            // first alu operand
    input  isa_word_t  id_reg_2,                 // rt value
    input  isa_word_t  id_sign_extend_result,    // extended immediate
    output isa_word_t  mux_operand_2,            // second alu operand
    input  isa_word_t  id_instruction,           // source of the jump target
    output isa_word_t  pc_overload_value,
    input  reg_idx_t   id_reg_1_idx,             // rs field
    input  reg_idx_t   id_reg_2_idx,             // rt field
    input  reg_idx_t   id_reg_dest_idx,          // rd field
    output reg_idx_t   mux_reg_1_idx,
    output reg_idx_t   mux_reg_2_idx,
    output reg_idx_t   mux_reg_dest_idx,
    output logic       reg_1_valid,              // rs really read, for hazard logic
    output logic       reg_2_valid               // rt really read
);

    logic j_type_normal;   // j or jal, target taken from the instruction

    assign j_type_normal = j_instruction || jal_instruction;

    assign reg_1_valid = !(j_type_normal || shift_instruction);
    assign reg_2_valid = r_type_instruction || branch_instruction;

    assign pc_offset   = condition_satisfied && branch_instruction && !id_no_op;
    assign pc_overload = (j_type_normal || jr_instruction) && !id_no_op;

    // pseudo-direct target keeps the pc's upper four bits
    assign pc_overload_value = j_type_normal ?
                               {id_pc[ISA_WIDTH-1:ADDRESS_WIDTH+2],
                                id_instruction[ADDRESS_WIDTH-1:0],
                                2'b00} :
                               id_reg_1;   // jr jumps to rs

    assign mux_operand_1 = jal_instruction    ? id_pc                     :
                           shift_instruction  ? isa_word_t'(shift_amount) : id_reg_1;
    assign mux_operand_2 = i_type_instruction ? id_sign_extend_result     :
                           jal_instruction    ? isa_word_t'(4)            : id_reg_2;

    assign mux_reg_1_idx = reg_1_valid ? id_reg_1_idx : '0;   // index 0 never hazards
    assign mux_reg_2_idx = reg_2_valid ? id_reg_2_idx : '0;

    always_comb begin
        case ({i_type_instruction, branch_instruction || jr_instruction, jal_instruction})
            3'b100:  mux_reg_dest_idx = id_reg_2_idx;      // i type writes rt
            3'b010:  mux_reg_dest_idx = '0;                // branch and jr write nothing
            3'b001:  mux_reg_dest_idx = JAL_REG_IDX;
            default: mux_reg_dest_idx = id_reg_dest_idx;   // r type writes rd
        endcase
    end

    // fetch takes only one redirect per cycle
    assert property (@(posedge clk) disable iff (!rst_n) !(pc_offset && pc_overload))
        else $error("signal_mux: branch and jump redirect in the same cycle");

endmodule

`default_nettype wire

// File: logic/id_ex_reg.sv
`timescale 1ns/100ps
`default_nettype none

module id_ex_reg import decode_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      id_no_op,            // gap from fetch
    input  logic      instruction_active,  // some class strobe is high
    input  logic      reg_write_intent,
    input  alu_op_t   alu_op,
    input  isa_word_t mux_operand_1,
    input  isa_word_t mux_operand_2,
    input  reg_idx_t  mux_reg_1_idx,
    input  reg_idx_t  mux_reg_2_idx,
    input  reg_idx_t  mux_reg_dest_idx,
    output logic      ex_valid,            // execute holds a real instruction
    output logic      ex_reg_write,
    output alu_op_t   ex_alu_op,
    output isa_word_t ex_operand_1,
    output isa_word_t ex_operand_2,
    output reg_idx_t  ex_reg_1_idx,
    output reg_idx_t  ex_reg_2_idx,
    output reg_idx_t  ex_reg_dest_idx
);

    logic bubble;
    logic write_enable;

    assign bubble       = id_no_op || !instruction_active;
    assign write_enable = reg_write_intent && (mux_reg_dest_idx != '0);   // $0 stays zero

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_valid        <= 1'b0;
            ex_reg_write    <= 1'b0;
            ex_alu_op       <= '0;
            ex_operand_1    <= '0;
            ex_operand_2    <= '0;
            ex_reg_1_idx    <= '0;
            ex_reg_2_idx    <= '0;
            ex_reg_dest_idx <= '0;
        end else begin
            ex_valid        <= !bubble;
            ex_reg_write    <= !bubble && write_enable;
            ex_alu_op       <= bubble ? ALU_NOP : alu_op;   // bubble does nothing in execute
            ex_operand_1    <= mux_operand_1;
            ex_operand_2    <= mux_operand_2;
            ex_reg_1_idx    <= mux_reg_1_idx;
            ex_reg_2_idx    <= mux_reg_2_idx;
            ex_reg_dest_idx <= mux_reg_dest_idx;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) ex_reg_write |-> ex_valid)
        else $error("id_ex_reg: register write from a bubble");

endmodule

`default_nettype wire

// File: logic/decode_stage.sv
`timescale 1ns/100ps
`default_nettype none

module decode_stage import decode_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  isa_word_t id_instruction,     // from fetch
    input  isa_word_t id_pc,
    input  logic      id_no_op,           // fetch gap
    input  isa_word_t id_reg_1,           // register file read ports
    input  isa_word_t id_reg_2,
    output logic      pc_offset,          // same-cycle redirects to fetch
    output logic      pc_overload,
    output isa_word_t pc_offset_value,
    output isa_word_t pc_overload_value,
    output logic      reg_1_valid,        // to hazard logic
    output logic      reg_2_valid,
    output logic      ex_valid,           // registered execute-stage bundle
    output logic      ex_reg_write,
    output alu_op_t   ex_alu_op,
    output isa_word_t ex_operand_1,
    output isa_word_t ex_operand_2,
    output reg_idx_t  ex_reg_1_idx,
    output reg_idx_t  ex_reg_2_idx,
    output reg_idx_t  ex_reg_dest_idx
);

    logic       i_type_instruction;
    logic       r_type_instruction;
    logic       j_instruction;
    logic       jr_instruction;
    logic       jal_instruction;
    logic       branch_instruction;
    logic       shift_instruction;
    logic       instruction_active;
    logic       reg_write_intent;
    logic       condition_satisfied;
    alu_op_t    alu_op;
    isa_word_t  id_sign_extend_result;
    isa_word_t  mux_operand_1;
    isa_word_t  mux_operand_2;
    shift_amt_t shift_amount;
    reg_idx_t   id_reg_1_idx;
    reg_idx_t   id_reg_2_idx;
    reg_idx_t   id_reg_dest_idx;
    reg_idx_t   mux_reg_1_idx;
    reg_idx_t   mux_reg_2_idx;
    reg_idx_t   mux_reg_dest_idx;

    assign id_reg_1_idx    = id_instruction[25:21];   // rs
    assign id_reg_2_idx    = id_instruction[20:16];   // rt
    assign id_reg_dest_idx = id_instruction[15:11];   // rd
    assign shift_amount    = id_instruction[10:6];

    assign instruction_active = i_type_instruction || r_type_instruction || j_instruction ||
                                jr_instruction || jal_instruction || branch_instruction ||
                                shift_instruction;

    // branch displacement comes straight from the extender, operand 2 carries rt
    assign pc_offset_value = id_sign_extend_result;

    // every net above carries the same name as the ports it joins
    control_unit    u_control_unit    (.*);
    branch_resolver u_branch_resolver (.*);
    signal_mux      u_signal_mux      (.*);
    id_ex_reg       u_id_ex_reg       (.*);

endmodule

`default_nettype wire

// File: bench/decode_stage_tb.sv
`timescale 1ns/100ps
`default_nettype none

module decode_stage_tb import decode_pkg::*; ();

    localparam int NUM_INSTR    = 2000;
    localparam int RESET_CYCLES = 5;
    localparam int CYCLE_LIMIT  = NUM_INSTR + RESET_CYCLES + 20;

    logic      clk;
    logic      rst_n;
    isa_word_t id_instruction;
    isa_word_t id_pc;
    logic      id_no_op;
    isa_word_t id_reg_1;
    isa_word_t id_reg_2;
    logic      pc_offset;
    logic      pc_overload;
    isa_word_t pc_offset_value;
    isa_word_t pc_overload_value;
    logic      reg_1_valid;
    logic      reg_2_valid;
    logic      ex_valid;
    logic      ex_reg_write;
    alu_op_t   ex_alu_op;
    isa_word_t ex_operand_1;
    isa_word_t ex_operand_2;
    reg_idx_t  ex_reg_1_idx;
    reg_idx_t  ex_reg_2_idx;
    reg_idx_t  ex_reg_dest_idx;

    logic [15:0] lfsr_state;
    int          cycle_count;

    logic      exp_pc_offset;     // same-cycle expectations
    logic      exp_pc_overload;
    logic      exp_branch;
    isa_word_t exp_overload_value;
    isa_word_t exp_offset_value;
    logic      exp_reg_1_valid;
    logic      exp_reg_2_valid;
    logic      nxt_valid;         // what the register loads at the next edge
    logic      nxt_write;
    alu_op_t   nxt_alu_op;
    isa_word_t nxt_operand_1;
    isa_word_t nxt_operand_2;
    reg_idx_t  nxt_idx_1;
    reg_idx_t  nxt_idx_2;
    reg_idx_t  nxt_dest;
    logic      prv_valid;         // loaded at the last edge, seen on ex_ now
    logic      prv_write;
    alu_op_t   prv_alu_op;
    isa_word_t prv_operand_1;
    isa_word_t prv_operand_2;
    reg_idx_t  prv_idx_1;
    reg_idx_t  prv_idx_2;
    reg_idx_t  prv_dest;

    decode_stage u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;   // 8 ns period
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        logic feedback;
        feedback  = state[15] ^ state[13] ^ state[12] ^ state[10];
        lfsr_next = {state[14:0], feedback};
    endfunction

    task automatic draw_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);   // one step per bit
            value      = {value[30:0], lfsr_state[0]};
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[ERROR] %s expected %h actual %h", name, expected, actual);
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
    endtask

    task automatic drive_random_instruction();
        logic [31:0] choice;
        logic [31:0] low;
        logic [31:0] bad_op;
        logic [31:0] value;
        logic [31:0] same;
        logic [31:0] gap;
        isa_word_t   instr;
        draw_bits(5, choice);
        draw_bits(26, low);      // register fields, immediate or target
        draw_bits(5, bad_op);
        case (choice % 17)
            0:  instr = {OP_RTYPE, low[25:6], FN_ADD};
            1:  instr = {OP_RTYPE, low[25:6], FN_SUB};
            2:  instr = {OP_RTYPE, low[25:6], FN_AND};
            3:  instr = {OP_RTYPE, low[25:6], FN_OR};
            4:  instr = {OP_RTYPE, low[25:6], FN_SLT};
            5:  instr = {OP_RTYPE, low[25:6], FN_SLL};
            6:  instr = {OP_RTYPE, low[25:6], FN_SRL};
            7:  instr = {OP_RTYPE, low[25:6], FN_JR};
            8:  instr = {OP_ADDI, low[25:0]};
            9:  instr = {OP_ANDI, low[25:0]};
            10: instr = {OP_ORI, low[25:0]};
            11: instr = {OP_SLTI, low[25:0]};
            12: instr = {OP_BEQ, low[25:0]};
            13: instr = {OP_BNE, low[25:0]};
            14: instr = {OP_J, low[25:0]};
            15: instr = {OP_JAL, low[25:0]};
            default: instr = {1'b1, bad_op[4:0], low[25:0]};   // 1xxxxx is unused
        endcase
        id_instruction <= instr;
        draw_bits(32, value);
        id_pc <= value;
        draw_bits(32, value);
        id_reg_1 <= value;
        draw_bits(2, same);
        if (same == 0) begin
            id_reg_2 <= value;   // equal registers, one time in four
        end else begin
            draw_bits(32, value);
            id_reg_2 <= value;
        end
        draw_bits(3, gap);
        id_no_op <= (gap == 0);
    endtask

    task automatic compute_expected();
        opcode_t   opcode;
        funct_t    funct;
        logic      is_r;
        logic      is_shift;
        logic      is_jr;
        logic      is_i;
        logic      is_j;
        logic      is_jal;
        logic      intent;
        logic      bubble;
        isa_word_t ext;
        reg_idx_t  rs;
        reg_idx_t  rt;
        reg_idx_t  rd;
        opcode     = id_instruction[31:26];
        funct      = id_instruction[5:0];
        rs         = id_instruction[25:21];
        rt         = id_instruction[20:16];
        rd         = id_instruction[15:11];
        is_shift   = (opcode == OP_RTYPE) && (funct == FN_SLL || funct == FN_SRL);
        is_r       = (opcode == OP_RTYPE) && (is_shift || funct == FN_ADD || funct == FN_SUB ||
                     funct == FN_AND || funct == FN_OR || funct == FN_SLT);
        is_jr      = (opcode == OP_RTYPE) && (funct == FN_JR);
        is_i       = (opcode == OP_ADDI || opcode == OP_ANDI ||
                      opcode == OP_ORI || opcode == OP_SLTI);
        exp_branch = (opcode == OP_BEQ || opcode == OP_BNE);
        is_j       = (opcode == OP_J);
        is_jal     = (opcode == OP_JAL);
        intent     = is_r || is_i || is_jal;
        nxt_alu_op = ALU_NOP;   // j, jr and undefined
        if (is_r) begin
            case (funct)
                FN_ADD:  nxt_alu_op = ALU_ADD;
                FN_SUB:  nxt_alu_op = ALU_SUB;
                FN_AND:  nxt_alu_op = ALU_AND;
                FN_OR:   nxt_alu_op = ALU_OR;
                FN_SLT:  nxt_alu_op = ALU_SLT;
                FN_SLL:  nxt_alu_op = ALU_SLL;
                default: nxt_alu_op = ALU_SRL;
            endcase
        end else if (opcode == OP_ADDI || is_jal) begin
            nxt_alu_op = ALU_ADD;
        end else if (opcode == OP_SLTI) begin
            nxt_alu_op = ALU_SLT;
        end else if (opcode == OP_ANDI) begin
            nxt_alu_op = ALU_AND;
        end else if (opcode == OP_ORI) begin
            nxt_alu_op = ALU_OR;
        end else if (exp_branch) begin
            nxt_alu_op = ALU_SUB;
        end
        if (opcode == OP_ANDI || opcode == OP_ORI) begin
            ext = {16'h0000, id_instruction[15:0]};              // logical immediates
        end else begin
            ext = {{16{id_instruction[15]}}, id_instruction[15:0]};
        end
        exp_offset_value = ext;
        exp_pc_offset    = exp_branch && !id_no_op &&
                           ((opcode == OP_BEQ) == (id_reg_1 == id_reg_2));
        exp_pc_overload  = (is_j || is_jal || is_jr) && !id_no_op;
        exp_overload_value = is_jr ? id_reg_1 : {id_pc[31:28], id_instruction[25:0], 2'b00};
        exp_reg_1_valid  = !(is_j || is_jal || is_shift);
        exp_reg_2_valid  = is_r || exp_branch;
        nxt_operand_1    = is_jal ? id_pc : is_shift ? {27'd0, id_instruction[10:6]} : id_reg_1;
        nxt_operand_2    = is_i ? ext : is_jal ? 32'd4 : id_reg_2;
        nxt_idx_1        = exp_reg_1_valid ? rs : 5'd0;
        nxt_idx_2        = exp_reg_2_valid ? rt : 5'd0;
        nxt_dest         = is_i ? rt : (exp_branch || is_jr) ? 5'd0 : is_jal ? 5'd31 : rd;
        bubble           = id_no_op || !(is_r || is_jr || is_i || exp_branch || is_j || is_jal);
        nxt_valid        = !bubble;
        nxt_write        = !bubble && intent && (nxt_dest != 5'd0);
        if (bubble) begin
            nxt_alu_op = ALU_NOP;
        end
    endtask

    task automatic check_same_cycle();
        check_value("pc_offset", 32'(exp_pc_offset), 32'(pc_offset));
        check_value("pc_overload", 32'(exp_pc_overload), 32'(pc_overload));
        if (exp_pc_overload) begin
            check_value("pc_overload_value", exp_overload_value, pc_overload_value);
        end
        if (exp_branch) begin
            check_value("pc_offset_value", exp_offset_value, pc_offset_value);
        end
        check_value("reg_1_valid", 32'(exp_reg_1_valid), 32'(reg_1_valid));
        check_value("reg_2_valid", 32'(exp_reg_2_valid), 32'(reg_2_valid));
    endtask

    task automatic check_registered();
        check_value("ex_valid", 32'(prv_valid), 32'(ex_valid));
        check_value("ex_reg_write", 32'(prv_write), 32'(ex_reg_write));
        check_value("ex_alu_op", 32'(prv_alu_op), 32'(ex_alu_op));
        check_value("ex_operand_1", prv_operand_1, ex_operand_1);
        check_value("ex_operand_2", prv_operand_2, ex_operand_2);
        check_value("ex_reg_1_idx", 32'(prv_idx_1), 32'(ex_reg_1_idx));
        check_value("ex_reg_2_idx", 32'(prv_idx_2), 32'(ex_reg_2_idx));
        check_value("ex_reg_dest_idx", 32'(prv_dest), 32'(ex_reg_dest_idx));
    endtask

    initial begin
        rst_n          = 1'b0;
        id_instruction = '0;
        id_pc          = '0;
        id_no_op       = 1'b1;
        id_reg_1       = '0;
        id_reg_2       = '0;
        lfsr_state     = 16'd49811;
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(posedge clk);
            rst_n <= 1'b0;
            @(negedge clk);
            check_value("reset ex_valid", 32'd0, 32'(ex_valid));
            check_value("reset ex_reg_write", 32'd0, 32'(ex_reg_write));
        end
        {prv_valid, prv_write, prv_alu_op, prv_operand_1, prv_operand_2} = '0;   // reset image
        {prv_idx_1, prv_idx_2, prv_dest} = '0;
        for (int n = 0; n <= NUM_INSTR; n++) begin
            @(posedge clk);
            rst_n <= 1'b1;   // seen by the register one edge later
            if (n < NUM_INSTR) begin
                drive_random_instruction();
            end else begin
                id_no_op <= 1'b1;   // flush the last instruction
            end
            @(negedge clk);
            check_registered();
            compute_expected();
            check_same_cycle();
            prv_valid     = nxt_valid;
            prv_write     = nxt_write;
            prv_alu_op    = nxt_alu_op;
            prv_operand_1 = nxt_operand_1;
            prv_operand_2 = nxt_operand_2;
            prv_idx_1     = nxt_idx_1;
            prv_idx_2     = nxt_idx_2;
            prv_dest      = nxt_dest;
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
logic/decode_pkg.sv
logic/control_unit.sv
logic/branch_resolver.sv
logic/signal_mux.sv
logic/id_ex_reg.sv
logic/decode_stage.sv
bench/decode_stage_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module decode_stage_tb -f sources.f -o decode_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/decode_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

echo "$output" | grep -qx "TEST RESULT: PASS" || exit 1
exit 0
